//--- design/ifu_pkg.sv
`default_nettype none

package ifu_pkg;

  // instruction classes as seen by the pc sequencer
  typedef enum logic [2:0] {
    CLS_SEQ     = 3'd0,
    CLS_JAL     = 3'd1,
    CLS_CTRL    = 3'd2,
    CLS_LOAD    = 3'd3,
    CLS_FENCE_I = 3'd4
  } inst_class_e;

  // sequencer to cache
  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
  } fetch_req_t;

  // cache to predecoder and sequencer
  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    logic [31:0] inst;
  } fetch_rsp_t;

  // new-pc message, local jal or execute
  typedef struct packed {
    logic        valid;
    logic [31:0] target;
  } redirect_t;

  // rv32 major opcodes
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;

  // fence.i with zero fields
  localparam logic [31:0] INST_FENCE_I = 32'h0000_100f;

endpackage

`default_nettype wire

//--- design/ifu_pc_gen.sv
`timescale 1ns/100ps
`default_nettype none

module ifu_pc_gen import ifu_pkg::*; #(
  parameter logic [31:0] PC_INIT = 32'h8000_0000
) (
  input  wire         clk,
  input  wire         rst,
  input  wire fetch_rsp_t  rsp_i,
  input  wire         accept_i,
  input  wire inst_class_e class_i,
  input  wire redirect_t   jal_redirect_i,
  input  wire redirect_t   exec_redirect_i,
  output fetch_req_t  req_o
);

  logic [31:0] pc_q;
  logic        wait_q;
  logic        load_q;
  logic [31:0] pc_seq;

  assign pc_seq = pc_q + 32'd4;

  // request whenever not parked on a redirect
  assign req_o.valid = !wait_q;
  assign req_o.pc    = pc_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q   <= PC_INIT;
      wait_q <= 1'b0;
      load_q <= 1'b0;
    end else if (wait_q) begin
      if (exec_redirect_i.valid) begin
        wait_q <= 1'b0;
        // a load already stepped past itself
        if (!load_q) begin
          pc_q <= exec_redirect_i.target;
        end
      end
    end else if (accept_i) begin
      if (jal_redirect_i.valid) begin
        pc_q <= jal_redirect_i.target;
      end else begin
        case (class_i)
          CLS_CTRL: begin
            wait_q <= 1'b1;
            load_q <= 1'b0;
          end
          CLS_LOAD: begin
            wait_q <= 1'b1;
            load_q <= 1'b1;
            pc_q   <= pc_seq;
          end
          default: begin
            pc_q <= pc_seq;
          end
        endcase
      end
    end
  end

  // execute only answers a stalled control or load
  a_redirect_when_waiting: assert property (
    @(posedge clk) disable iff (rst)
    exec_redirect_i.valid |-> wait_q
  ) else $error("exec redirect while not waiting");

  // no refill may complete while parked
  a_no_rsp_while_waiting: assert property (
    @(posedge clk) disable iff (rst)
    rsp_i.valid |-> !wait_q
  ) else $error("fetch response while waiting for a redirect");

endmodule

`default_nettype wire

//--- design/ifu_l1i.sv
`timescale 1ns/100ps
`default_nettype none

module ifu_l1i import ifu_pkg::*; #(
  parameter int L1I_SETS = 4
) (
  input  wire             clk,
  input  wire             rst,
  input  wire fetch_req_t req_i,
  input  wire             flush_i,
  output fetch_rsp_t      rsp_o,
  output logic [31:0]     araddr_o,
  output logic            arvalid_o,
  input  wire [31:0]      rdata_i,
  input  wire             rvalid_i
);

  localparam int IDX_W = $clog2(L1I_SETS);
  localparam int TAG_W = 32 - IDX_W - 3;

  typedef enum logic [1:0] {
    ST_IDLE   = 2'd0,
    ST_FIRST  = 2'd1,
    ST_GAP    = 2'd2,
    ST_SECOND = 2'd3
  } fill_state_e;

  fill_state_e state_q;
  fill_state_e state_d;

  logic [L1I_SETS-1:0] valid_q;
  logic [TAG_W-1:0]    tag_q  [L1I_SETS];
  logic [31:0]         data_q [L1I_SETS][2];

  logic [IDX_W-1:0] idx;
  logic [TAG_W-1:0] tag;
  logic             off;
  logic             lookup_hit;
  logic             hit;
  logic             fill_done;

  // line address split: tag | index | word | byte
  assign idx = req_i.pc[IDX_W+2:3];
  assign tag = req_i.pc[31:IDX_W+3];
  assign off = req_i.pc[2];

  assign lookup_hit = valid_q[idx] && (tag_q[idx] == tag);
  assign hit        = req_i.valid && (state_q == ST_IDLE) && lookup_hit;
  assign fill_done  = (state_q == ST_SECOND) && rvalid_i;

  // even word first, odd word second
  assign arvalid_o = (state_q == ST_FIRST) || (state_q == ST_SECOND);
  assign araddr_o  = {req_i.pc[31:3], (state_q == ST_SECOND), 2'b00};

  assign rsp_o.valid = hit || fill_done;
  assign rsp_o.pc    = req_i.pc;

  always_comb begin
    rsp_o.inst = data_q[idx][off];
    // odd word comes straight off the bus
    if (fill_done && off) begin
      rsp_o.inst = rdata_i;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (req_i.valid && !lookup_hit) begin
          state_d = ST_FIRST;
        end
      end
      ST_FIRST: begin
        if (rvalid_i) begin
          state_d = ST_GAP;
        end
      end
      ST_GAP: begin
        state_d = ST_SECOND;
      end
      ST_SECOND: begin
        if (rvalid_i) begin
          state_d = ST_IDLE;
        end
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // flush wins over a line completing in the same cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (flush_i) begin
      valid_q <= '0;
    end else if (fill_done) begin
      valid_q[idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if ((state_q == ST_FIRST) && rvalid_i) begin
      data_q[idx][0] <= rdata_i;
    end
    if (fill_done) begin
      data_q[idx][1] <= rdata_i;
      tag_q[idx]     <= tag;
    end
  end

  // bus request is a level until the response pulse
  a_ar_stable: assert property (
    @(posedge clk) disable iff (rst)
    (arvalid_o && !rvalid_i) |=> (arvalid_o && $stable(araddr_o))
  ) else $error("araddr/arvalid changed before rvalid");

  a_no_rvalid_idle: assert property (
    @(posedge clk) disable iff (rst)
    (state_q == ST_IDLE) |-> !rvalid_i
  ) else $error("rvalid with no read outstanding");

endmodule

`default_nettype wire

//--- design/ifu_predecode.sv
`timescale 1ns/100ps
`default_nettype none

module ifu_predecode import ifu_pkg::*; (
  input  wire fetch_rsp_t rsp_i,
  input  wire             inst_ready_i,
  output logic            inst_valid_o,
  output logic [31:0]     inst_o,
  output logic [31:0]     pc_o,
  output logic            accept_o,
  output inst_class_e     class_o,
  output redirect_t       jal_redirect_o,
  output logic            flush_o
);

  logic [6:0]  opcode;
  logic [31:0] j_imm;

  assign inst_valid_o = rsp_i.valid;
  assign inst_o       = rsp_i.inst;
  assign pc_o         = rsp_i.pc;
  assign accept_o     = rsp_i.valid && inst_ready_i;

  assign opcode = rsp_i.inst[6:0];

  // j-type immediate, bit 0 always zero
  assign j_imm = {{11{rsp_i.inst[31]}}, rsp_i.inst[31], rsp_i.inst[19:12],
                  rsp_i.inst[20], rsp_i.inst[30:21], 1'b0};

  always_comb begin
    if (rsp_i.inst == INST_FENCE_I) begin
      class_o = CLS_FENCE_I;
    end else begin
      case (opcode)
        OP_JAL: begin
          class_o = CLS_JAL;
        end
        OP_JALR, OP_BRANCH, OP_SYSTEM: begin
          class_o = CLS_CTRL;
        end
        OP_LOAD: begin
          class_o = CLS_LOAD;
        end
        default: begin
          class_o = CLS_SEQ;
        end
      endcase
    end
  end

  // strobes only on an actual transfer
  assign jal_redirect_o.valid  = accept_o && (class_o == CLS_JAL);
  assign jal_redirect_o.target = rsp_i.pc + j_imm;
  assign flush_o               = accept_o && (class_o == CLS_FENCE_I);

endmodule

`default_nettype wire

//--- design/ifu_top.sv
`timescale 1ns/100ps
`default_nettype none

module ifu_top import ifu_pkg::*; #(
  parameter logic [31:0] PC_INIT  = 32'h8000_0000,
  parameter int          L1I_SETS = 4
) (
  input  wire            clk,
  input  wire            rst,
  output logic [31:0]    araddr_o,
  output logic           arvalid_o,
  input  wire [31:0]     rdata_i,
  input  wire            rvalid_i,
  output logic           inst_valid_o,
  output logic [31:0]    inst_o,
  output logic [31:0]    pc_o,
  input  wire            inst_ready_i,
  input  wire redirect_t exec_redirect_i
);

  fetch_req_t  fetch_req;
  fetch_rsp_t  fetch_rsp;
  logic        accept;
  inst_class_e inst_class;
  redirect_t   jal_redirect;
  logic        flush;

  ifu_pc_gen #(
    .PC_INIT(PC_INIT)
  ) u_pc_gen (
    .clk            (clk),
    .rst            (rst),
    .rsp_i          (fetch_rsp),
    .accept_i       (accept),
    .class_i        (inst_class),
    .jal_redirect_i (jal_redirect),
    .exec_redirect_i(exec_redirect_i),
    .req_o          (fetch_req)
  );

  ifu_l1i #(
    .L1I_SETS(L1I_SETS)
  ) u_l1i (
    .clk      (clk),
    .rst      (rst),
    .req_i    (fetch_req),
    .flush_i  (flush),
    .rsp_o    (fetch_rsp),
    .araddr_o (araddr_o),
    .arvalid_o(arvalid_o),
    .rdata_i  (rdata_i),
    .rvalid_i (rvalid_i)
  );

  ifu_predecode u_predecode (
    .rsp_i         (fetch_rsp),
    .inst_ready_i  (inst_ready_i),
    .inst_valid_o  (inst_valid_o),
    .inst_o        (inst_o),
    .pc_o          (pc_o),
    .accept_o      (accept),
    .class_o       (inst_class),
    .jal_redirect_o(jal_redirect),
    .flush_o       (flush)
  );

endmodule

`default_nettype wire

//--- tb/tb_ifu_model.svh
`ifndef TB_IFU_MODEL_SVH
`define TB_IFU_MODEL_SVH

logic [31:0] image [logic [31:0]];
logic        shadow_valid [L1I_SETS];
logic [31:0] shadow_line  [L1I_SETS];

// word at any address that the program does not set
function automatic logic [31:0] fill_word(input logic [31:0] addr);
  logic [11:0] imm;
  imm = addr[31:20] ^ addr[19:8] ^ {addr[9:2], 4'h0};
  // addi x0, x0, imm
  return {imm, 13'd0, 7'b0010011};
endfunction

function automatic logic [31:0] mem_word(input logic [31:0] addr);
  if (image.exists(addr)) begin
    return image[addr];
  end
  return fill_word(addr);
endfunction

function automatic logic [31:0] encode_jal(input int offset);
  logic [20:0] o;
  o = offset[20:0];
  return {o[20], o[10:1], o[11], o[19:12], 5'd0, 7'b1101111};
endfunction

function automatic logic [31:0] expected_next_pc(input logic [31:0] pc,
                                                 input logic [31:0] inst,
                                                 input logic [31:0] target);
  logic [31:0] imm;
  imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
  if (inst == 32'h0000_100f) begin
    return pc + 32'd4;
  end
  case (inst[6:0])
    7'b1101111: return pc + imm;
    7'b1100111, 7'b1100011, 7'b1110011: return target;
    default: return pc + 32'd4;
  endcase
endfunction

// returns 1 when the line was not cached, then records it
function automatic logic shadow_access(input logic [31:0] pc);
  int   idx;
  logic miss;
  idx  = int'((pc >> 3) % L1I_SETS);
  miss = !shadow_valid[idx] || (shadow_line[idx] != (pc >> 3));
  shadow_valid[idx] = 1'b1;
  shadow_line[idx]  = pc >> 3;
  return miss;
endfunction

function automatic void shadow_clear();
  for (int i = 0; i < L1I_SETS; i++) begin
    shadow_valid[i] = 1'b0;
    shadow_line[i]  = '0;
  end
endfunction

`endif

//--- tb/tb_ifu.sv
`timescale 1ns/100ps
`default_nettype none

module tb_ifu import ifu_pkg::*; ();

  localparam logic [31:0] B = 32'h0000_1000;
  localparam int L1I_SETS = 4;
  localparam int MAX_CYCLES = 20000;
  localparam int IDLE_MAX = 200;

  logic clk;
  logic rst;
  logic [31:0] araddr_o;
  logic arvalid_o;
  logic [31:0] rdata_i;
  logic rvalid_i;
  logic inst_valid_o;
  logic [31:0] inst_o;
  logic [31:0] pc_o;
  logic inst_ready_i;
  redirect_t exec_redirect_i;

  `include "tb_ifu_model.svh"

  logic [31:0] read_q[$];
  int errors, transfers, reads, branch_cnt, redir_cnt;
  logic [31:0] exp_pc, redir_target;
  logic waiting, bp_en, rewritten, done;
  logic prev_valid, prev_ready;
  logic [31:0] prev_inst, prev_pc;

  ifu_top #(
    .PC_INIT (B),
    .L1I_SETS(L1I_SETS)
  ) u_ifu_top (
    .clk            (clk),
    .rst            (rst),
    .araddr_o       (araddr_o),
    .arvalid_o      (arvalid_o),
    .rdata_i        (rdata_i),
    .rvalid_i       (rvalid_i),
    .inst_valid_o   (inst_valid_o),
    .inst_o         (inst_o),
    .pc_o           (pc_o),
    .inst_ready_i   (inst_ready_i),
    .exec_redirect_i(exec_redirect_i)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic string test_name(input logic [31:0] pc);
    if (pc < B + 32'h40) return "loop_branch";
    if (pc < B + 32'h60) return "jal";
    if (pc < B + 32'h68) return "load_redirect";
    if (pc < B + 32'h80) return "fence_i";
    return "backpressure";
  endfunction

  task automatic check_transfer();
    logic [31:0] t_pc;
    logic [31:0] t_inst;
    logic [31:0] target;
    logic [31:0] rd;
    string name;
    t_pc = pc_o;
    t_inst = inst_o;
    target = '0;
    name = test_name(exp_pc);
    if (waiting) begin
      $display("transfer at pc %h while waiting for an execute redirect", t_pc);
      errors++;
    end
    if (t_pc != exp_pc) begin
      $display("[ERROR] %s pc: expected %h actual %h", name, exp_pc, t_pc);
      errors++;
    end
    if (t_inst != mem_word(t_pc)) begin
      $display("[ERROR] %s inst: expected %h actual %h", name, mem_word(t_pc), t_inst);
      errors++;
    end
    if (shadow_access(t_pc)) begin
      if (read_q.size() < 2) begin
        $display("[ERROR] %s refill reads: expected 2 actual %0d", name, read_q.size());
        errors++;
        read_q.delete();
      end else begin
        rd = read_q.pop_front();
        if (rd != {t_pc[31:3], 3'b000}) begin
          $display("[ERROR] %s even read: expected %h actual %h",
                   name, {t_pc[31:3], 3'b000}, rd);
          errors++;
        end
        rd = read_q.pop_front();
        if (rd != {t_pc[31:3], 3'b100}) begin
          $display("[ERROR] %s odd read: expected %h actual %h",
                   name, {t_pc[31:3], 3'b100}, rd);
          errors++;
        end
      end
    end
    if (read_q.size() != 0) begin
      $display("[ERROR] %s extra reads: expected 0 actual %0d", name, read_q.size());
      errors++;
      read_q.delete();
    end
    if (t_inst == 32'h0000_100f) begin
      shadow_clear();
    end
    if (t_inst[6:0] == 7'b1100011) begin
      target = (branch_cnt == 0) ? B + 32'h08 : B + 32'h40;
      branch_cnt++;
    end else if (t_inst[6:0] == 7'b0000011) begin
      target = 32'h0bad_f00c;
    end
    if (t_inst[6:0] == 7'b1100011 || t_inst[6:0] == 7'b0000011) begin
      waiting = 1'b1;
      redir_target = target;
      redir_cnt = 2 + int'($urandom % 4);
    end
    exp_pc = expected_next_pc(t_pc, t_inst, target);
    // new code lands behind the fence.i
    if (t_pc == B + 32'h68 && !rewritten) begin
      image[B + 32'h68] = encode_jal(32'h18);
      rewritten = 1'b1;
    end
    if (t_pc >= B + 32'h80) bp_en = 1'b1;
    if (t_pc == B + 32'hbc) done = 1'b1;
    transfers++;
  endtask

  // bus memory model
  initial begin
    int idle;
    int d;
    logic timed_out;
    rvalid_i = 1'b0;
    rdata_i = '0;
    timed_out = 1'b0;
    while (!timed_out) begin
      idle = 0;
      @(negedge clk);
      while (!arvalid_o && idle <= 1000) begin
        @(negedge clk);
        idle++;
      end
      if (!arvalid_o) begin
        timed_out = 1'b1;
      end else begin
        read_q.push_back(araddr_o);
        reads++;
        d = 1 + int'($urandom % 4);
        repeat (d) @(posedge clk);
        #1;
        rvalid_i = 1'b1;
        rdata_i = mem_word(araddr_o);
        @(posedge clk);
        #1;
        rvalid_i = 1'b0;
        rdata_i = '0;
      end
    end
    $display("no bus read seen for 1000 cycles");
    $display("Simulation failed");
    $finish;
  end

  initial begin
    int cycles;
    int idle;
    void'($urandom(32'hd29a56c5));
    rst = 1'b1;
    inst_ready_i = 1'b1;
    exec_redirect_i = '0;
    errors = 0;
    transfers = 0;
    reads = 0;
    branch_cnt = 0;
    redir_cnt = 0;
    redir_target = '0;
    waiting = 1'b0;
    bp_en = 1'b0;
    rewritten = 1'b0;
    done = 1'b0;
    prev_valid = 1'b0;
    prev_ready = 1'b1;
    prev_inst = '0;
    prev_pc = '0;
    image[B + 32'h20] = 32'h0000_0063;
    image[B + 32'h40] = encode_jal(32'h20);
    image[B + 32'h60] = 32'h0000_2003;
    image[B + 32'h6c] = 32'h0000_100f;
    image[B + 32'h70] = encode_jal(-8);
    shadow_clear();
    exp_pc = B;
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;
    cycles = 0;
    idle = 0;
    while (!done && cycles < MAX_CYCLES && idle < IDLE_MAX) begin
      @(posedge clk);
      #1;
      exec_redirect_i = '0;
      if (redir_cnt > 0) begin
        redir_cnt--;
        if (redir_cnt == 0) begin
          exec_redirect_i.valid = 1'b1;
          exec_redirect_i.target = redir_target;
          waiting = 1'b0;
        end
      end
      inst_ready_i = bp_en ? ($urandom % 3 != 0) : 1'b1;
      @(negedge clk);
      // held response must not move under back-pressure
      if (prev_valid && !prev_ready) begin
        if (!inst_valid_o || inst_o != prev_inst || pc_o != prev_pc) begin
          $display("[ERROR] backpressure hold: expected %h@%h actual %h@%h valid %b",
                   prev_inst, prev_pc, inst_o, pc_o, inst_valid_o);
          errors++;
        end
      end
      if (inst_valid_o && inst_ready_i) begin
        check_transfer();
        idle = 0;
      end else begin
        idle++;
      end
      prev_valid = inst_valid_o;
      prev_ready = inst_ready_i;
      prev_inst = inst_o;
      prev_pc = pc_o;
      cycles++;
    end
    if (!done) begin
      $display("fetch stopped before the end of the program, last expected pc %h", exp_pc);
      errors++;
    end
    $display("errors: %0d, transfers: %0d, bus reads: %0d", errors, transfers, reads);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
+incdir+tb
design/ifu_pkg.sv
design/ifu_pc_gen.sv
design/ifu_l1i.sv
design/ifu_predecode.sv
design/ifu_top.sv
tb/tb_ifu.sv

//--- run.sh
#!/bin/sh
# compile and run the fetch front end testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
  --top-module tb_ifu \
  -f project.f \
  -o tb_ifu_sim

./obj_dir/tb_ifu_sim | tee sim.log

if grep -q "Simulation completed successfully" sim.log; then
  exit 0
else
  exit 1
fi
